// File: hw/rot_settings.svh
// Address rotator global settings
// Widths of the address and count paths, and the latency of the modular pipeline
`ifndef ROT_SETTINGS_SVH
`define ROT_SETTINGS_SVH

// Width of addresses, offsets and modulus values
`define ROT_ADDR_W 8

// Count is one bit wider so that a full 256-entry job still fits
`define ROT_COUNT_W 9

// Cycles from an index entering the modular pipeline to its address leaving it
`define ROT_PIPE_DEPTH 3

`endif

// File: hw/rot_pkg.sv
// Address rotator types
// Opcode and controller state enumerations shared by the design
`default_nettype none

package rot_pkg;

  // ************************************************************
  // Opcodes
  // ************************************************************

  // Add walks the buffer forward from the offset, subtract walks it backward
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } rot_op_e;

  // ************************************************************
  // Controller states
  // ************************************************************

  // One pass through all four states makes a complete req/ack job
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RUN   = 2'd1,
    ST_DRAIN = 2'd2,
    ST_ACK   = 2'd3
  } rot_state_e;

endpackage

`default_nettype wire

// File: hw/mod_addsub.sv
// Modular add/subtract pipeline
// Turns each index into (index +/- offset) mod modulus over three register stages
`default_nettype none
`include "rot_settings.svh"

module mod_addsub import rot_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire rot_op_e                op,
  input  wire logic [`ROT_ADDR_W-1:0] offset,
  input  wire logic [`ROT_ADDR_W-1:0] modulus,
  input  wire logic [`ROT_ADDR_W-1:0] index,
  input  wire logic                   index_valid,
  output logic      [`ROT_ADDR_W-1:0] addr,
  output logic                        addr_valid,
  output logic                        busy
);

  // Stage 1 holds the raw index
  logic [`ROT_ADDR_W-1:0] s1_index;
  logic                   s1_valid;

  // Stage 2 holds the unresolved sum or difference, one bit wider than the operands
  logic [`ROT_ADDR_W:0]   s2_sum;
  logic                   s2_valid;

  // Wrapped value that stage 3 loads into the output register
  logic [`ROT_ADDR_W:0]   s2_wrap;
  logic [`ROT_ADDR_W-1:0] resolved;

  // ************************************************************
  // Stage 1 and stage 2
  // ************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= index_valid;
      s2_valid <= s1_valid;
    end
  end

  // Payload registers; the valid bits above qualify them
  always_ff @(posedge clk) begin
    s1_index <= index;
    if (op == OP_ADD) begin
      s2_sum <= {1'b0, s1_index} + {1'b0, offset};
    end else begin
      // The top bit becomes a borrow flag when offset exceeds the index
      s2_sum <= {1'b0, s1_index} - {1'b0, offset};
    end
  end

  // ************************************************************
  // Stage 3 resolve into range
  // ************************************************************

  always_comb begin
    if (op == OP_ADD) begin
      // A sum at or above the modulus has wrapped once past the end
      s2_wrap = s2_sum - {1'b0, modulus};
      resolved = (s2_sum >= {1'b0, modulus}) ? s2_wrap[`ROT_ADDR_W-1:0] : s2_sum[`ROT_ADDR_W-1:0];
    end else begin
      // A borrow means the difference went below zero, so fold it back up
      s2_wrap = s2_sum + {1'b0, modulus};
      resolved = s2_sum[`ROT_ADDR_W] ? s2_wrap[`ROT_ADDR_W-1:0] : s2_sum[`ROT_ADDR_W-1:0];
    end
  end

  // The output reads zero whenever no valid address is present
  always_ff @(posedge clk) begin
    if (reset) begin
      addr       <= '0;
      addr_valid <= 1'b0;
    end else begin
      addr       <= s2_valid ? resolved : '0;
      addr_valid <= s2_valid;
    end
  end

  // Any stage holding an item means the job has not fully drained
  assign busy = s1_valid | s2_valid | addr_valid;

endmodule

`default_nettype wire

// File: hw/index_counter.sv
// Index counter for the address rotator
// Issues indices 0 to count-1 on consecutive cycles and flags the final one
`default_nettype none
`include "rot_settings.svh"

module index_counter (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    start,
  input  wire logic [`ROT_COUNT_W-1:0] count,
  output logic      [`ROT_ADDR_W-1:0]  index,
  output logic                         index_valid,
  output logic                         last
);

  // Number of indices still to issue, including the one on the output now
  logic [`ROT_COUNT_W-1:0] remaining;

  // Stands in for last when a job asks for no indices at all
  logic                    empty_pulse;

  always_ff @(posedge clk) begin
    if (reset) begin
      index_valid <= 1'b0;
      empty_pulse <= 1'b0;
      remaining   <= '0;
      index       <= '0;
    end else if (start) begin
      index       <= '0;
      remaining   <= count;
      index_valid <= (count != '0);
      empty_pulse <= (count == '0);
    end else begin
      empty_pulse <= 1'b0;
      if (index_valid) begin
        // Stop after the index that used up the count
        if (remaining == `ROT_COUNT_W'(1)) begin
          index_valid <= 1'b0;
        end else begin
          index <= index + 1'b1;
        end
        remaining <= remaining - 1'b1;
      end
    end
  end

  // last stays combinational so it lines up with the final valid index
  assign last = (index_valid && (remaining == `ROT_COUNT_W'(1))) || empty_pulse;

endmodule

`default_nettype wire

// File: hw/rot_ctrl.sv
// Address rotator controller
// Runs the four-phase req/ack handshake and sequences the counter and pipeline drain
`default_nettype none
`include "rot_settings.svh"

module rot_ctrl import rot_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   req,
  input  wire rot_op_e                op,
  input  wire logic [`ROT_ADDR_W-1:0] offset,
  input  wire logic [`ROT_ADDR_W-1:0] modulus,
  input  wire logic                   last,
  input  wire logic                   busy,
  output logic                        ack,
  output logic                        start,
  output rot_op_e                     job_op,
  output logic      [`ROT_ADDR_W-1:0] job_offset,
  output logic      [`ROT_ADDR_W-1:0] job_modulus
);

  rot_state_e state;

  // ************************************************************
  // Handshake FSM
  // ************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      ack   <= 1'b0;
      start <= 1'b0;
    end else begin
      // start is a single-cycle pulse unless the idle branch sets it
      start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (req) begin
            state <= ST_RUN;
            start <= 1'b1;
          end
        end
        ST_RUN: begin
          // The final index is entering the pipeline on this edge
          if (last) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          // Wait for the last address to leave before acknowledging
          if (!busy) begin
            state <= ST_ACK;
            ack   <= 1'b1;
          end
        end
        ST_ACK: begin
          if (!req) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
          end
        end
        default: begin
          state <= ST_IDLE;
          ack   <= 1'b0;
        end
      endcase
    end
  end

  // ************************************************************
  // Job registers
  // ************************************************************

  // Captured when the job starts and held until the next one begins
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) begin
      job_op      <= op;
      job_offset  <= offset;
      job_modulus <= modulus;
    end
  end

endmodule

`default_nettype wire

// File: hw/addr_rotator.sv
// Circular-buffer address rotator
// Accepts a job over req/ack and streams count wrapped addresses, one per cycle
`default_nettype none
`include "rot_settings.svh"

module addr_rotator import rot_pkg::*; (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    req,
  input  wire rot_op_e                 op,
  input  wire logic [`ROT_ADDR_W-1:0]  offset,
  input  wire logic [`ROT_ADDR_W-1:0]  modulus,
  input  wire logic [`ROT_COUNT_W-1:0] count,
  output logic                         ack,
  output logic      [`ROT_ADDR_W-1:0]  addr,
  output logic                         addr_valid
);

  // Controller to counter
  logic                   start;
  logic                   last;

  // Counter to pipeline
  logic [`ROT_ADDR_W-1:0] index;
  logic                   index_valid;

  // Latched job fields, stable for a whole job
  rot_op_e                job_op;
  logic [`ROT_ADDR_W-1:0] job_offset;
  logic [`ROT_ADDR_W-1:0] job_modulus;

  // Pipeline occupancy back to the controller
  logic                   busy;

  rot_ctrl rot_ctrl_inst (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .op          (op),
    .offset      (offset),
    .modulus     (modulus),
    .last        (last),
    .busy        (busy),
    .ack         (ack),
    .start       (start),
    .job_op      (job_op),
    .job_offset  (job_offset),
    .job_modulus (job_modulus)
  );

  // count comes straight from the host, which holds it while req is high
  index_counter index_counter_inst (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .count       (count),
    .index       (index),
    .index_valid (index_valid),
    .last        (last)
  );

  mod_addsub mod_addsub_inst (
    .clk         (clk),
    .reset       (reset),
    .op          (job_op),
    .offset      (job_offset),
    .modulus     (job_modulus),
    .index       (index),
    .index_valid (index_valid),
    .addr        (addr),
    .addr_valid  (addr_valid),
    .busy        (busy)
  );

endmodule

`default_nettype wire

// File: test/addr_rotator_tb.sv
// Testbench for the circular-buffer address rotator
// Runs directed and random req/ack jobs and checks each address against the index rule
`default_nettype none
`include "rot_settings.svh"

module addr_rotator_tb import rot_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int CLK_PERIOD       = 100;
  localparam int RANDOM_JOBS      = 40;
  localparam int MAX_RANDOM_COUNT = 255;
  localparam int DIRECTED_JOBS    = 4;
  localparam int DIRECTED_COUNTS  = 10 + 16 + 0 + 8;
  // Handshake, start, pipeline fill and ack hold around every job
  localparam int JOB_OVERHEAD     = `ROT_PIPE_DEPTH + 12;
  localparam int WATCHDOG_CYCLES  = DIRECTED_COUNTS + RANDOM_JOBS * MAX_RANDOM_COUNT
                                  + (DIRECTED_JOBS + RANDOM_JOBS) * JOB_OVERHEAD + 20;

  logic                    clk;
  logic                    reset;
  logic                    req;
  rot_op_e                 op;
  logic [`ROT_ADDR_W-1:0]  offset;
  logic [`ROT_ADDR_W-1:0]  modulus;
  logic [`ROT_COUNT_W-1:0] count;
  logic                    ack;
  logic [`ROT_ADDR_W-1:0]  addr;
  logic                    addr_valid;

  // Addresses seen by the monitor in the current job, with the cycle each one arrived on
  logic [`ROT_ADDR_W-1:0]  got_q[$];
  int                      cyc_q[$];
  int                      cycle = 0;
  int                      seed;

  addr_rotator addr_rotator_inst (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .op         (op),
    .offset     (offset),
    .modulus    (modulus),
    .count      (count),
    .ack        (ack),
    .addr       (addr),
    .addr_valid (addr_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ************************************************************
  // Checking helpers and reference model
  // ************************************************************

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
      abort_run();
    end
  endtask

  // Address i of a job is (i + offset) mod modulus, or (i - offset) mod modulus
  function automatic int expected_addr(input rot_op_e job_op, input int i, input int off,
                                       input int modu);
    if (job_op == OP_ADD) begin
      return (i + off) % modu;
    end else begin
      // Adding modulus first keeps the difference non-negative
      return (i + modu - off) % modu;
    end
  endfunction

  // Outputs are sampled on the falling edge, halfway between driving edges
  always @(negedge clk) begin
    cycle = cycle + 1;
    if (!reset) begin
      if (addr_valid && ack) begin
        $display("An address was issued while ack was high");
        abort_run();
      end else if (addr_valid) begin
        got_q.push_back(addr);
        cyc_q.push_back(cycle);
      end else begin
        // The stream reads zero between valid addresses
        check_eq("addr", 32'(addr), 32'd0);
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timed out after %0d clock cycles before all jobs finished", WATCHDOG_CYCLES);
    abort_run();
  end

  // ************************************************************
  // Job driver
  // ************************************************************

  // One full four-phase handshake, then the collected stream is checked
  task automatic run_job(input rot_op_e job_op, input int job_offset, input int job_modulus,
                         input int job_count);
    int i;
    @(posedge clk);
    #1;
    got_q.delete();
    cyc_q.delete();
    op      = job_op;
    offset  = `ROT_ADDR_W'(job_offset);
    modulus = `ROT_ADDR_W'(job_modulus);
    count   = `ROT_COUNT_W'(job_count);
    req     = 1'b1;
    @(negedge clk);
    while (!ack) begin
      @(negedge clk);
    end
    // ack must hold for as long as req stays high
    repeat (2) begin
      @(negedge clk);
      check_eq("ack", 32'(ack), 32'd1);
    end
    @(posedge clk);
    #1;
    req = 1'b0;
    @(negedge clk);
    check_eq("ack", 32'(ack), 32'd1);
    @(negedge clk);
    check_eq("ack", 32'(ack), 32'd0);
    // Let the monitor take this edge's sample before the stream is checked
    #1;
    check_eq("address count", 32'(got_q.size()), 32'(job_count));
    for (i = 0; i < job_count; i++) begin
      check_eq("addr", 32'(got_q[i]), 32'(expected_addr(job_op, i, job_offset, job_modulus)));
      // Addresses arrive on consecutive cycles with no gap
      check_eq("addr cycle", 32'(cyc_q[i]), 32'(cyc_q[0] + i));
    end
  endtask

  // ************************************************************
  // Tests
  // ************************************************************

  task automatic test_idle_outputs();
    repeat (5) begin
      @(negedge clk);
      check_eq("ack", 32'(ack), 32'd0);
      check_eq("addr_valid", 32'(addr_valid), 32'd0);
      check_eq("addr", 32'(addr), 32'd0);
    end
  endtask

  task automatic test_add_job();
    run_job(OP_ADD, 7, 10, 10);
    // Spot checks against the stream 7, 8, 9, 0, ..., 6
    check_eq("addr", 32'(got_q[0]), 32'd7);
    check_eq("addr", 32'(got_q[3]), 32'd0);
    check_eq("addr", 32'(got_q[9]), 32'd6);
  endtask

  task automatic test_sub_job();
    run_job(OP_SUB, 5, 16, 16);
    // Index 0 lands on 11 and index 5 wraps back to 0
    check_eq("addr", 32'(got_q[0]), 32'd11);
    check_eq("addr", 32'(got_q[4]), 32'd15);
    check_eq("addr", 32'(got_q[5]), 32'd0);
  endtask

  task automatic test_empty_job();
    run_job(OP_ADD, 3, 12, 0);
    run_job(OP_SUB, 3, 12, 8);
  endtask

  task automatic test_random_jobs();
    int unsigned r;
    int          n;
    int          modu;
    int          off;
    int          cnt;
    rot_op_e     rop;
    for (n = 0; n < RANDOM_JOBS; n++) begin
      r    = $random(seed);
      rop  = r[0] ? OP_SUB : OP_ADD;
      r    = $random(seed);
      modu = int'(r % 255) + 1;
      r    = $random(seed);
      off  = int'(r % modu);
      r    = $random(seed);
      cnt  = int'(r % (modu + 1));
      run_job(rop, off, modu, cnt);
    end
  endtask

  initial begin
    seed    = 17742;
    reset   = 1'b1;
    req     = 1'b0;
    op      = OP_ADD;
    offset  = '0;
    modulus = '0;
    count   = '0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    test_idle_outputs();
    test_add_job();
    test_sub_job();
    test_empty_job();
    test_random_jobs();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hw
hw/rot_pkg.sv
hw/mod_addsub.sv
hw/index_counter.sv
hw/rot_ctrl.sv
hw/addr_rotator.sv
test/addr_rotator_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the address rotator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module addr_rotator_tb -o addr_rotator_sim

# A fatal error ends the simulator with a non-zero status, so the log decides the result
./obj_dir/addr_rotator_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF ">>> FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if ! grep -qF ">>> PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation finished cleanly"
